// ==== src/fetchPkg.sv ====
package fetchPkg;

    // Datapath widths of the fetch stage
    localparam int addrWidth = 32;
    localparam int instrWidth = 32;

    // A line carries a whole block of instructions from the memory controller
    localparam int numLines = 16;
    localparam int wordsPerLine = 16;
    localparam int lineWidth = wordsPerLine * instrWidth;

    // The address splits into byte, word offset, index and tag fields from the bottom up
    localparam int byteBits = 2;
    localparam int offsetBits = $clog2(wordsPerLine);
    localparam int indexBits = $clog2(numLines);

    // Number of low address bits that select a byte inside one line
    localparam int lineByteBits = byteBits + offsetBits;

    // Whatever is left above the index is compared as the tag
    localparam int tagBits = addrWidth - indexBits - lineByteBits;

    // First fetch address after reset
    localparam logic [addrWidth-1:0] resetVector = '0;

    // Miss controller state codes
    localparam logic [1:0] stIdle = 2'd0;
    localparam logic [1:0] stRequest = 2'd1;
    localparam logic [1:0] stRefill = 2'd2;

endpackage

// ==== src/programCounter.sv ====
`timescale 1ns/1ps

// Program counter register of the fetch stage
// Halt and stall are kept apart so a halted core can later be gated on its own
module programCounter (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           stall,
    input  logic                           halt,
    input  logic [fetchPkg::addrWidth-1:0] nextPC,
    output logic [fetchPkg::addrWidth-1:0] pc
);

    import fetchPkg::*;

    logic hold;

    // Either a halted core or a pipeline hazard freezes the current address
    assign hold = halt | stall;

    // The next address always comes from outside, since branches resolve later
    // in the pipeline
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetVector;
        end else if (!hold) begin
            pc <= nextPC;
        end
    end

endmodule

// ==== src/instrCache.sv ====
`timescale 1ns/1ps

// Direct-mapped instruction cache
// Lookup is purely combinational so the instruction follows the address in the same cycle
// A refill writes a complete line in one edge when the memory controller strobes fillValid
module instrCache (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [fetchPkg::addrWidth-1:0]  addr,
    input  logic                            fillValid,
    input  logic [fetchPkg::indexBits-1:0]  fillIndex,
    input  logic [fetchPkg::lineWidth-1:0]  fillData,
    input  logic                            fillBusy,
    output logic [fetchPkg::instrWidth-1:0] instr,
    output logic                            hit,
    output logic                            miss
);

    import fetchPkg::*;

    // Line storage, one entry per index
    logic [lineWidth-1:0] lineData [numLines];

    // Stored tag of each line
    logic [tagBits-1:0] tagArr [numLines];

    // One valid bit per line, the only state cleared by reset
    logic [numLines-1:0] validArr;

    // Fields of the fetch address
    logic [tagBits-1:0] addrTag;
    logic [indexBits-1:0] addrIndex;
    logic [offsetBits-1:0] addrOffset;

    // The line picked by the index, before word selection
    logic [lineWidth-1:0] selLine;

    // Tag sits in the top bits of the address
    assign addrTag = addr[addrWidth-1 -: tagBits];

    // Index sits right above the byte offset inside the line
    assign addrIndex = addr[lineByteBits +: indexBits];

    // Word offset skips the two byte bits, instructions are word aligned
    assign addrOffset = addr[byteBits +: offsetBits];

    // Read the indexed line out of the array
    assign selLine = lineData[addrIndex];

    // A hit needs a valid line whose tag matches
    assign hit = validArr[addrIndex] && (tagArr[addrIndex] == addrTag);

    // Hide the miss while a refill is outstanding
    // so a single miss produces a single memory request
    assign miss = !hit && !fillBusy;

    // Word zero of a line sits in the lowest bits, so the lowest address
    // of the line maps to fillData[31:0]
    assign instr = selLine[addrOffset * instrWidth +: instrWidth];

    // Valid bits are set by a fill and only cleared by reset
    // There is no other invalidation path
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validArr <= '0;
        end else if (fillValid) begin
            validArr[fillIndex] <= 1'b1;
        end
    end

    // Line data and tags are written together on the fill strobe
    // The program counter is held through the whole miss, so the tag
    // of the current address belongs to the line being filled
    always_ff @(posedge clk) begin
        if (fillValid) begin
            lineData[fillIndex] <= fillData;
            tagArr[fillIndex] <= addrTag;
        end
    end

endmodule

// ==== src/missController.sv ====
`timescale 1ns/1ps

// Miss controller between the instruction cache and the external memory controller
// A miss seen in IDLE sends one line request and then waits for the fill
module missController (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           miss,
    input  logic [fetchPkg::addrWidth-1:0] pc,
    input  logic                           fillValid,
    output logic                           memReq,
    output logic [fetchPkg::addrWidth-1:0] memReqAddr,
    output logic [fetchPkg::indexBits-1:0] fillIndex,
    output logic                           fillBusy
);

    import fetchPkg::*;

    logic [1:0] state;
    logic [1:0] nextState;
    logic startMiss;

    // A new miss is only taken from IDLE
    assign startMiss = (state == stIdle) && miss;

    // The cache masks further misses while this is high
    assign fillBusy = (state != stIdle);

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (miss) begin
                    nextState = stRequest;
                end
            end
            stRequest: begin
                // The memory side answers exactly once, no timeout here
                if (fillValid) begin
                    nextState = stRefill;
                end
            end
            stRefill: begin
                // One cycle for the freshly written line to show up as a hit
                nextState = stIdle;
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stIdle;
            memReq <= 1'b0;
        end else begin
            state <= nextState;
            // Registered strobe, high for the one cycle after the miss was seen
            memReq <= startMiss;
        end
    end

    // Line address and index are captured once per miss
    always_ff @(posedge clk) begin
        if (startMiss) begin
            memReqAddr <= {pc[addrWidth-1:lineByteBits], {lineByteBits{1'b0}}};
            fillIndex <= pc[lineByteBits +: indexBits];
        end
    end

endmodule

// ==== src/fetchStage.sv ====
`timescale 1ns/1ps

// Instruction fetch stage top level
// Joins the program counter, the instruction cache and the miss controller
module fetchStage (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            halt,
    input  logic                            stallDMAMem,
    input  logic                            blockInstruction,
    input  logic [fetchPkg::addrWidth-1:0]  nextPC,
    input  logic                            fillValid,
    input  logic [fetchPkg::lineWidth-1:0]  fillData,
    output logic [fetchPkg::addrWidth-1:0]  pc,
    output logic [fetchPkg::addrWidth-1:0]  pcPlus4,
    output logic [fetchPkg::instrWidth-1:0] instr,
    output logic                            instrValid,
    output logic                            memReq,
    output logic [fetchPkg::addrWidth-1:0]  memReqAddr
);

    import fetchPkg::*;

    logic stall;
    logic cacheStall;
    logic hit;
    logic miss;
    logic fillBusy;
    logic [indexBits-1:0] fillIndex;

    // The cache holds the PC on a fresh miss and for as long as a refill
    // leaves the current address without a hit
    // In the REFILL cycle the line is already readable so fetch moves on
    assign cacheStall = miss | (fillBusy & ~hit);

    // Hazards from the memory stage, the decode stage and the cache
    // Halt goes to the program counter on its own port
    assign stall = stallDMAMem | blockInstruction | cacheStall;

    // Sequential address for the branch logic downstream
    assign pcPlus4 = pc + addrWidth'(4);

    // The instruction is usable exactly when the lookup hits
    assign instrValid = hit;

    programCounter pcReg (
        .clk    (clk),
        .rstN   (rstN),
        .stall  (stall),
        .halt   (halt),
        .nextPC (nextPC),
        .pc     (pc)
    );

    instrCache iCache (
        .clk       (clk),
        .rstN      (rstN),
        .addr      (pc),
        .fillValid (fillValid),
        .fillIndex (fillIndex),
        .fillData  (fillData),
        .fillBusy  (fillBusy),
        .instr     (instr),
        .hit       (hit),
        .miss      (miss)
    );

    // Runs on regardless of halt so a refill always completes
    missController missCtrl (
        .clk        (clk),
        .rstN       (rstN),
        .miss       (miss),
        .pc         (pc),
        .fillValid  (fillValid),
        .memReq     (memReq),
        .memReqAddr (memReqAddr),
        .fillIndex  (fillIndex),
        .fillBusy   (fillBusy)
    );

endmodule

// ==== verif/clockGen.sv ====
`timescale 1ns/1ps

// Clock and reset source for the fetch stage testbench
module clockGen (
    output logic clk,
    output logic rstN
);

    // 20 ns period, first rising edge at 10 ns
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset is held over 16 rising edges and released 1 ns after the last one,
    // like every other stimulus
    initial begin
        rstN = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
    end

endmodule

// ==== verif/memModel.sv ====
`timescale 1ns/1ps

// Behavioral memory controller for the fetch stage testbench
// Each line request is answered exactly once, a few cycles later, with a whole line
// whose instructions follow a fixed rule on their byte address
module memModel #(
    parameter logic [31:0] fillKey = 32'hA5A5_0000
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           memReq,
    input  logic [fetchPkg::addrWidth-1:0] memReqAddr,
    input  logic [3:0]                     replyDelay,
    output logic                           fillValid,
    output logic [fetchPkg::lineWidth-1:0] fillData
);

    import fetchPkg::*;

    logic [addrWidth-1:0] lineAddr;
    int waitCycles;

    // Word w of the line holds the instruction at base + 4w, word zero in the lowest bits
    function automatic logic [lineWidth-1:0] buildLine(input logic [addrWidth-1:0] base);
        logic [lineWidth-1:0] line;
        line = '0;
        for (int w = 0; w < wordsPerLine; w++) begin
            line[w*instrWidth +: instrWidth] = (base + addrWidth'(4 * w)) ^ fillKey;
        end
        return line;
    endfunction

    initial begin
        fillValid = 1'b0;
        fillData = '0;
    end

    // Requests are picked up at the falling edge where memReq is settled
    always begin
        @(negedge clk);
        if (rstN && memReq) begin
            lineAddr = memReqAddr;
            waitCycles = int'(replyDelay);
            // The fill goes out 1 ns after the last counted rising edge
            repeat (waitCycles - 1) @(posedge clk);
            #1;
            fillData = buildLine(lineAddr);
            fillValid = 1'b1;
            @(posedge clk);
            #1;
            fillValid = 1'b0;
        end
    end

endmodule

// ==== verif/fetchStageTb.sv ====
`timescale 1ns/1ps

// Testbench top for the instruction fetch stage
// A monitor checks every cycle at the falling edge, the tests steer nextPC and the hazards
module fetchStageTb;

    import fetchPkg::*;

    // Instruction at byte address A is A xor fillKey
    localparam logic [31:0] fillKey = 32'hA5A5_0000;
    localparam int waitLimit = 40;
    localparam logic [31:0] confA = 32'h0000_0100;
    // Same index as confA with the next tag up
    localparam logic [31:0] confB = 32'h0000_0500;

    logic clk;
    logic rstN;
    logic halt;
    logic stallDMAMem;
    logic blockInstruction;
    logic [addrWidth-1:0] nextPC;
    logic fillValid;
    logic [lineWidth-1:0] fillData;
    logic [addrWidth-1:0] pc;
    logic [addrWidth-1:0] pcPlus4;
    logic [instrWidth-1:0] instr;
    logic instrValid;
    logic memReq;
    logic [addrWidth-1:0] memReqAddr;
    logic [3:0] replyDelay;

    string testName;
    int errCount;
    int testErrStart;
    int passCount;
    int failCount;
    int reqCount;
    int startReq;
    int cycles;
    logic [31:0] lcgState;
    logic jumpPending;
    logic [31:0] jumpTarget;
    logic [31:0] held;
    logic [31:0] prevPc;
    logic prevValid;
    logic prevMemReq;
    logic havePrev;

    clockGen clkGen (.*);
    memModel #(.fillKey(fillKey)) mem (.*);
    fetchStage i_dut (.*);

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] expectedInstr(input logic [31:0] addr);
        return addr ^ fillKey;
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        $display("ERR %s %s: expected %h, actual %h", testName, what, expVal, actVal);
        errCount++;
    endtask

    task automatic reportFailure(input string what);
        $display("Error in %s: %s", testName, what);
        errCount++;
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrStart = errCount;
    endtask

    task automatic endTest();
        if (errCount == testErrStart) begin
            passCount++;
            $display("PASS %s", testName);
        end else begin
            failCount++;
            $display("FAIL %s", testName);
        end
    endtask

    // One clock step, inputs change 1 ns after the rising edge
    // A pending jump keeps nextPC on its target until the target is reached
    task automatic tick();
        logic [31:0] rnd;
        @(posedge clk);
        #1;
        if (jumpPending && pc == jumpTarget) begin
            jumpPending = 1'b0;
        end
        nextPC = jumpPending ? jumpTarget : pcPlus4;
        rnd = nextRandom();
        replyDelay = 4'd2 + {1'b0, rnd[18:16]};
    endtask

    task automatic waitValid();
        int n;
        n = 0;
        while (!instrValid && n < waitLimit) begin
            tick();
            n++;
        end
        if (!instrValid) begin
            reportFailure("timed out waiting for a valid instruction");
        end
    endtask

    task automatic jumpTo(input logic [31:0] target);
        int n;
        n = 0;
        jumpTarget = target;
        jumpPending = 1'b1;
        while (!(pc == target && instrValid) && n < waitLimit) begin
            tick();
            n++;
        end
        jumpPending = 1'b0;
        if (!(pc == target && instrValid)) begin
            reportFailure("timed out before the jump target was fetched");
        end
    endtask

    // Hold one hazard for five cycles, then fetch has to resume at the next word
    task automatic checkHold(input int source);
        waitValid();
        held = pc;
        case (source)
            0: halt = 1'b1;
            1: stallDMAMem = 1'b1;
            default: blockInstruction = 1'b1;
        endcase
        repeat (5) begin
            tick();
            assert (pc == held) else reportMismatch("pc under stall", held, pc);
        end
        halt = 1'b0;
        stallDMAMem = 1'b0;
        blockInstruction = 1'b0;
        tick();
        assert (pc == held + 32'd4) else reportMismatch("pc after stall", held + 32'd4, pc);
    endtask

    // Cycle checks at the falling edge, where every DUT output has settled
    always @(negedge clk) begin
        if (rstN !== 1'b1) begin
            havePrev = 1'b0;
            prevMemReq = 1'b0;
        end else begin
            assert (pcPlus4 == pc + 32'd4) else reportMismatch("pcPlus4", pc + 32'd4, pcPlus4);
            if (instrValid) begin
                assert (instr == expectedInstr(pc))
                    else reportMismatch("instr", expectedInstr(pc), instr);
            end
            if (memReq) begin
                reqCount++;
                // The request names the line of the address that missed
                assert (memReqAddr == (pc & ~32'h3F))
                    else reportMismatch("memReqAddr", pc & ~32'h3F, memReqAddr);
                assert (!prevMemReq) else reportFailure("memReq was high for two cycles");
            end
            // Without a valid instruction the PC must not move
            if (havePrev && !prevValid) begin
                assert (pc == prevPc) else reportMismatch("pc during miss", prevPc, pc);
            end
            havePrev = 1'b1;
            prevValid = instrValid;
            prevPc = pc;
            prevMemReq = memReq;
        end
    end

    initial begin
        halt = 1'b0;
        stallDMAMem = 1'b0;
        blockInstruction = 1'b0;
        nextPC = resetVector;
        replyDelay = 4'd2;
        lcgState = 32'h7279_4a59;
        jumpPending = 1'b0;
        jumpTarget = '0;
        errCount = 0;
        passCount = 0;
        failCount = 0;
        reqCount = 0;

        startTest("reset state");
        cycles = 0;
        while (rstN !== 1'b1 && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (rstN !== 1'b1) begin
            reportFailure("reset was never released");
        end
        assert (pc == resetVector) else reportMismatch("pc", resetVector, pc);
        assert (!instrValid) else reportFailure("instrValid high right after reset");
        assert (!memReq && reqCount == 0) else reportFailure("memReq before any miss");
        endTest();

        startTest("cold miss");
        waitValid();
        assert (reqCount == 1) else reportMismatch("request count", 1, reqCount);
        assert (pc == resetVector) else reportMismatch("pc", resetVector, pc);
        endTest();

        // Walk the rest of line zero, then cross into line one
        startTest("sequential hits");
        startReq = reqCount;
        for (int i = 1; i < wordsPerLine; i++) begin
            tick();
            assert (pc == 32'(4 * i)) else reportMismatch("pc", 32'(4 * i), pc);
            assert (instrValid) else reportFailure("no hit inside a filled line");
        end
        assert (reqCount == startReq) else reportFailure("memReq inside a filled line");
        tick();
        waitValid();
        assert (pc == 32'h40) else reportMismatch("pc", 32'h40, pc);
        assert (reqCount == startReq + 1)
            else reportMismatch("request count", startReq + 1, reqCount);
        endTest();

        startTest("stall sources");
        for (int s = 0; s < 3; s++) begin
            checkHold(s);
        end
        endTest();

        // Two addresses that share one index evict each other
        startTest("conflict eviction");
        jumpTo(confA);
        startReq = reqCount;
        jumpTo(confB);
        assert (reqCount == startReq + 1)
            else reportMismatch("request count", startReq + 1, reqCount);
        startReq = reqCount;
        jumpTo(confA);
        assert (reqCount == startReq + 1)
            else reportMismatch("request count", startReq + 1, reqCount);
        endTest();

        // Eight tags over all indexes give a mix of hits and misses
        startTest("random targets");
        for (int k = 0; k < 40; k++) begin
            jumpTo(nextRandom() & 32'h0000_1FFC);
        end
        endTest();

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (errCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== fetchUnit.f ====
src/fetchPkg.sv
src/programCounter.sv
src/instrCache.sv
src/missController.sv
src/fetchStage.sv
verif/clockGen.sv
verif/memModel.sv
verif/fetchStageTb.sv

// ==== Makefile ====
# Verilator build and run of the fetch stage testbench

SRCS := $(shell cat fetchUnit.f)

.PHONY: all run clean

all: run

# The simulator is rebuilt only when a source or the file list changes
obj_dir/VfetchStageTb: fetchUnit.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module fetchStageTb -f fetchUnit.f

# The run fails unless the log holds the closing success line
run: obj_dir/VfetchStageTb
	./obj_dir/VfetchStageTb | tee sim.log
	grep -q '^Done: no errors$$' sim.log

clean:
	rm -rf obj_dir sim.log
